// File: alu_1clk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one-cycle alu: adder, compare,
// shifter, ffl1, logic, cmov,
// movhi and result mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module alu_1clk (
  unit_sel_if.alu     sel,
  input  logic        flag_i,
  input  logic        carry_i,
  unit_res_if.alu_src res
);
  import exec_cfg_pkg::*;
  import exec_isa_pkg::*;

  data_t              b_mux;
  logic               carry_in;
  data_t              add_res;
  logic               add_cout;
  logic               add_ovf;
  logic               is_add;
  logic               a_eq_b;
  logic               a_lts_b;
  logic               a_ltu_b;
  logic               flag_set;
  logic [SHAMT_W-1:0] shamt;
  data_t              shr_lsw;
  data_t              shr_msw;
  logic [2*DATA_W-1:0] shr_wide;
  data_t              shr_res;
  data_t              ffl1_res;
  logic [3:0]         logic_lut;
  data_t              logic_res;
  data_t              alu_mux;

  function automatic data_t bit_rev(input data_t in);
    data_t out;
    for (int i = 0; i < DATA_W; i++) begin
      out[DATA_W-1-i] = in[i];
    end
    return out;
  endfunction

  // adder, subtract is a + ~b + 1
  assign b_mux    = sel.do_sub ? ~sel.op_b : sel.op_b;
  assign carry_in = sel.do_sub | (sel.use_carry & carry_i);
  assign {add_cout, add_res} = {1'b0, sel.op_a} + {1'b0, b_mux} +
                               {{DATA_W{1'b0}}, carry_in};
  // same input signs, result sign flipped
  assign add_ovf = (sel.op_a[DATA_W-1] == b_mux[DATA_W-1]) &
                   (sel.op_a[DATA_W-1] ^ add_res[DATA_W-1]);
  assign is_add  = (sel.opc == OPC_ADD) | (sel.opc == OPC_ADDC) |
                   (sel.opc == OPC_SUB);

  assign a_eq_b  = (sel.op_a == sel.op_b);
  assign a_lts_b = add_res[DATA_W-1] ^ add_ovf;
  assign a_ltu_b = ~add_cout;  // borrow out

  always_comb begin
    case (sel.sec.cmp)
      CMP_EQ:  flag_set = a_eq_b;
      CMP_NE:  flag_set = ~a_eq_b;
      CMP_GTU: flag_set = ~(a_eq_b | a_ltu_b);
      CMP_GTS: flag_set = ~(a_eq_b | a_lts_b);
      CMP_GEU: flag_set = ~a_ltu_b;
      CMP_GES: flag_set = ~a_lts_b;
      CMP_LTU: flag_set = a_ltu_b;
      CMP_LTS: flag_set = a_lts_b;
      CMP_LEU: flag_set = a_eq_b | a_ltu_b;
      CMP_LES: flag_set = a_eq_b | a_lts_b;
      default: flag_set = 1'b0;
    endcase
  end

  // left shift = reverse, shift right, reverse back
  assign shamt   = sel.op_b[SHAMT_W-1:0];
  assign shr_lsw = (sel.sec.shr.kind == SHR_SLL) ? bit_rev(sel.op_a) : sel.op_a;
  assign shr_msw = (sel.sec.shr.kind == SHR_SRA) ? {DATA_W{sel.op_a[DATA_W-1]}} :
                   (sel.sec.shr.kind == SHR_ROR) ? sel.op_a : '0;
  assign shr_wide = {shr_msw, shr_lsw} >> shamt;
  assign shr_res  = (sel.sec.shr.kind == SHR_SLL) ? bit_rev(shr_wide[DATA_W-1:0]) :
                    shr_wide[DATA_W-1:0];

  // bit index plus one, zero when op_a is zero
  always_comb begin
    ffl1_res = '0;
    if (sel.sec.shr.fl1) begin
      for (int i = 0; i < DATA_W; i++) begin
        if (sel.op_a[i])
          ffl1_res = data_t'(i + 1);  // highest set bit wins
      end
    end else begin
      for (int i = DATA_W - 1; i >= 0; i--) begin
        if (sel.op_a[i])
          ffl1_res = data_t'(i + 1);  // lowest set bit wins
      end
    end
  end

  always_comb begin
    case (sel.opc)
      OPC_AND: logic_lut = 4'b1000;
      OPC_OR:  logic_lut = 4'b1110;
      OPC_XOR: logic_lut = 4'b0110;
      default: logic_lut = 4'b0000;
    endcase
    for (int i = 0; i < DATA_W; i++) begin
      logic_res[i] = logic_lut[{sel.op_a[i], sel.op_b[i]}];
    end
  end

  always_comb begin
    case (sel.opc)
      OPC_ADD, OPC_ADDC, OPC_SUB: alu_mux = add_res;
      OPC_AND, OPC_OR, OPC_XOR:   alu_mux = logic_res;
      OPC_SHRT:  alu_mux = shr_res;
      OPC_FFL1:  alu_mux = ffl1_res;
      OPC_CMOV:  alu_mux = flag_i ? sel.op_a : sel.op_b;
      OPC_MOVHI: alu_mux = {sel.imm[HALF_W-1:0], {HALF_W{1'b0}}};
      default:   alu_mux = '0;  // setflag leaves no data
    endcase
  end

  assign res.alu_valid  = sel.alu_go;
  assign res.alu_result = alu_mux;
  assign res.flag_set   = flag_set;
  assign res.setflag_op = sel.alu_go & sel.set_flag;
  assign res.add_op     = sel.alu_go & is_add;
  assign res.carry_out  = add_cout;
  assign res.s_ovf      = add_ovf;

endmodule

// File: compile.f
exec_cfg_pkg.sv
exec_isa_pkg.sv
exec_if.sv
exec_decode.sv
alu_1clk.sv
mul_pipe.sv
wb_result.sv
exec_top.sv
exec_properties.sv
exec_checker.sv
exec_tb.sv

// File: exec_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage data widths,
// derived sizes and word types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package exec_cfg_pkg;

  localparam int DATA_W  = 32;  // operand width
  localparam int HALF_W  = DATA_W / 2;  // multiplier half word
  localparam int SHAMT_W = 5;   // log2 of DATA_W

  // one register word
  typedef logic [DATA_W-1:0] data_t;

  // multiplier operand half
  typedef logic [HALF_W-1:0] half_t;

endpackage

// File: exec_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model, expected
// result queue and compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module exec_checker (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush_i,
  input  logic                padv_wb_i,
  input  logic                insn_valid_i,
  input  logic [3:0]          opc_i,
  input  logic [3:0]          sec_i,
  input  exec_cfg_pkg::data_t rfa_i,
  input  exec_cfg_pkg::data_t rfb_i,
  input  exec_cfg_pkg::data_t imm_i,
  input  logic                imm_sel_i,
  input  logic                flag_i,
  input  logic                carry_i,
  input  logic                exec_valid_i,
  input  exec_cfg_pkg::data_t wb_result_i,
  input  logic                wb_rdy_i,
  input  logic [5:0]          wb_flags_i,  // flag, carry, ovf pairs
  input  int                  test_id_i,
  input  logic                test_end_i,
  input  logic                all_done_i,
  output int                  err_total_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import exec_cfg_pkg::*;
  import exec_isa_pkg::*;

  string      names[5] = '{"alu_ops", "setflag", "mul_b2b", "backpressure", "flush"};
  data_t      q_res[$];
  logic [5:0] q_flags[$];
  int         q_due[$];   // 0 means no timing check
  int         cycle;
  int         n_chk;
  int         n_err;
  int         tot_chk;
  int         tot_err;
  bit         post_flush;
  logic       mul_s1;     // multiplier stage occupancy
  logic       mul_s2;

  assign err_total_o = tot_err;

  // one instruction, ok is low for codes that give no result
  function automatic void model(input logic [3:0] opc, input logic [3:0] sec,
      input data_t a, input data_t rb, input data_t imm, input logic isel,
      input logic flg, input logic cy, output data_t r, output logic [5:0] fl,
      output bit ok);
    data_t               b;
    logic                c;
    logic                v;
    logic                f;
    logic [2*DATA_W-1:0] w;
    b  = isel ? imm : rb;
    r  = '0;
    fl = '0;
    ok = 1'b1;
    case (opc)
      OPC_ADD, OPC_ADDC: begin
        {c, r} = {1'b0, a} + {1'b0, b} + ((opc == OPC_ADDC) ? cy : 1'b0);
        v  = (a[31] == b[31]) && (r[31] != a[31]);
        fl = {2'b00, c, !c, v, !v};
      end
      OPC_SUB: begin
        r  = a - b;
        c  = (a >= b);  // carry out of a + ~b + 1
        v  = (a[31] != b[31]) && (r[31] != a[31]);
        fl = {2'b00, c, !c, v, !v};
      end
      OPC_AND: r = a & b;
      OPC_OR:  r = a | b;
      OPC_XOR: r = a ^ b;
      OPC_MUL: r = a * b;
      OPC_SHRT: begin
        case (sec[1:0])
          2'd0: r = a << b[4:0];
          2'd1: r = a >> b[4:0];
          2'd2: r = $signed(a) >>> b[4:0];
          default: begin
            w = {a, a} >> b[4:0];
            r = w[DATA_W-1:0];
          end
        endcase
      end
      OPC_SETFLAG: begin
        case (sec)
          4'd0: f = (a == b);
          4'd1: f = (a != b);
          4'd2: f = (a > b);
          4'd3: f = ($signed(a) > $signed(b));
          4'd4: f = (a >= b);
          4'd5: f = ($signed(a) >= $signed(b));
          4'd6: f = (a < b);
          4'd7: f = ($signed(a) < $signed(b));
          4'd8: f = (a <= b);
          4'd9: f = ($signed(a) <= $signed(b));
          default: f = 1'b0;
        endcase
        fl = {f, !f, 4'b0000};
      end
      OPC_MOVHI: r = {imm[15:0], 16'h0000};
      OPC_CMOV:  r = flg ? a : b;
      OPC_FFL1: begin
        for (int i = 0; i < DATA_W; i++) begin
          if (a[i] && (r == 0 || sec[2]))
            r = i + 1;
        end
      end
      default: ok = 1'b0;
    endcase
  endfunction

  task automatic log_mismatch(input string what, input data_t exp, input data_t act);
    n_err++;
    $display("ERR %s %s expected %h actual %h", names[test_id_i], what, exp, act);
  endtask

  task automatic log_fault(input string what);
    n_err++;
    $display("test %s: %s", names[test_id_i], what);
  endtask

  always @(posedge clk) begin
    data_t      r;
    logic [5:0] fl;
    bit         ok;
    int         due;
    logic       exp_valid;
    cycle++;
    if (rst) begin
      q_res.delete();
      q_flags.delete();
      q_due.delete();
      post_flush = 0;
      mul_s1     = 1'b0;
      mul_s2     = 1'b0;
    end else begin
      if (post_flush) begin
        n_chk++;
        if (wb_rdy_i || wb_flags_i != 0)
          log_fault("ready or flag output still high after flush");
        post_flush = 0;
      end else if (wb_rdy_i) begin
        if (q_res.size() == 0) begin
          log_fault("wb_rdy_o high with no result expected");
        end else begin
          r   = q_res.pop_front();
          fl  = q_flags.pop_front();
          due = q_due.pop_front();
          n_chk++;
          if (wb_result_i !== r)
            log_mismatch("result", r, wb_result_i);
          if (wb_flags_i !== fl)
            log_mismatch("flags", fl, wb_flags_i);
          if (due != 0 && due != cycle)
            log_mismatch("ready cycle", due, cycle);
        end
      end
      if (!padv_wb_i) begin
        if (wb_rdy_i)
          log_fault("wb_rdy_o high while padv_wb_i low");
        foreach (q_due[i]) q_due[i] = 0;  // stall shifts the timing
      end
      if (q_due.size() != 0 && q_due[0] != 0 && q_due[0] <= cycle) begin
        log_fault("expected result never showed up on wb_rdy_o");
        void'(q_res.pop_front());
        void'(q_flags.pop_front());
        void'(q_due.pop_front());
      end
      model(opc_i, sec_i, rfa_i, rfb_i, imm_i, imm_sel_i, flag_i, carry_i, r, fl, ok);
      // one-cycle op on the inputs or a product in stage two
      exp_valid = (insn_valid_i && ok && opc_i != OPC_MUL) || mul_s2;
      if (exec_valid_i !== exp_valid)
        log_mismatch("exec_valid", exp_valid, exec_valid_i);
      if (flush_i) begin
        q_res.delete();
        q_flags.delete();
        q_due.delete();
        post_flush = 1;
        mul_s1     = 1'b0;
        mul_s2     = 1'b0;
      end else begin
        if (insn_valid_i && ok) begin
          q_res.push_back(r);
          q_flags.push_back(fl);
          q_due.push_back(cycle + ((opc_i == OPC_MUL) ? 3 : 1));
        end
        // a held product freezes both stages while write-back stalls
        if (!mul_s2 || padv_wb_i) begin
          mul_s2 = mul_s1;
          mul_s1 = insn_valid_i && (opc_i == OPC_MUL);
        end
      end
      if (test_end_i) begin
        if (q_res.size() != 0)
          log_fault("results left over at end of test");
        $display("test %s: %0d checks, %0d errors", names[test_id_i], n_chk, n_err);
        tot_chk += n_chk;
        tot_err += n_err;
        n_chk = 0;
        n_err = 0;
      end
      if (all_done_i)
        $display("total: %0d checks, %0d errors", tot_chk, tot_err);
    end
  end

endmodule

// File: exec_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcode decode into unit
// strobes and operand select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module exec_decode (
  input  logic                   insn_valid_i,
  input  exec_isa_pkg::alu_opc_e opc_i,
  input  exec_isa_pkg::alu_sec_u sec_i,
  input  exec_cfg_pkg::data_t    rfa_i,
  input  exec_cfg_pkg::data_t    rfb_i,
  input  exec_cfg_pkg::data_t    imm_i,
  input  logic                   imm_sel_i,
  unit_sel_if.dec                sel
);
  import exec_isa_pkg::*;

  logic is_1clk;  // opcode finishes in the alu
  logic is_mul;

  always_comb begin
    is_1clk = 1'b0;
    is_mul  = 1'b0;
    case (opc_i)
      OPC_ADD, OPC_ADDC, OPC_SUB,
      OPC_AND, OPC_OR, OPC_XOR,
      OPC_SHRT, OPC_SETFLAG, OPC_MOVHI,
      OPC_CMOV, OPC_FFL1: is_1clk = 1'b1;
      OPC_MUL:            is_mul  = 1'b1;
      default: begin
        // reserved code, no unit started
        is_1clk = 1'b0;
        is_mul  = 1'b0;
      end
    endcase
  end

  assign sel.alu_go = insn_valid_i & is_1clk;
  assign sel.mul_go = insn_valid_i & is_mul;

  assign sel.opc  = opc_i;
  assign sel.sec  = sec_i;
  assign sel.op_a = rfa_i;
  assign sel.op_b = imm_sel_i ? imm_i : rfb_i;
  assign sel.imm  = imm_i;

  // compare runs through the subtractor
  assign sel.do_sub    = (opc_i == OPC_SUB) | (opc_i == OPC_SETFLAG);
  assign sel.use_carry = (opc_i == OPC_ADDC);
  assign sel.set_flag  = (opc_i == OPC_SETFLAG);

endmodule

// File: exec_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// unit select bus from decode
// unit result bus to write-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface unit_sel_if;
  import exec_cfg_pkg::*;
  import exec_isa_pkg::*;

  logic     mul_go;     // strobe into multiplier
  logic     alu_go;     // strobe into one-cycle alu
  alu_opc_e opc;
  alu_sec_u sec;
  data_t    op_a;
  data_t    op_b;       // rfb or immediate
  data_t    imm;
  logic     set_flag;
  logic     use_carry;
  logic     do_sub;

  modport dec (output mul_go, alu_go, opc, sec, op_a, op_b, imm,
               set_flag, use_carry, do_sub);
  modport alu (input alu_go, opc, sec, op_a, op_b, imm,
               set_flag, use_carry, do_sub);
  modport mul (input mul_go, op_a, op_b);
endinterface

interface unit_res_if;
  import exec_cfg_pkg::*;

  // one-cycle alu half
  logic  alu_valid;
  data_t alu_result;
  logic  flag_set;
  logic  setflag_op;
  logic  add_op;
  logic  carry_out;
  logic  s_ovf;
  // multiplier half
  logic  mul_valid;    // stage two full
  data_t mul_result;

  modport alu_src (output alu_valid, alu_result, flag_set, setflag_op,
                   add_op, carry_out, s_ovf);
  modport mul_src (output mul_valid, mul_result);
  modport wb (input alu_valid, alu_result, flag_set, setflag_op, add_op,
              carry_out, s_ovf, mul_valid, mul_result);
endinterface

// File: exec_isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer opcode encodings,
// compare and shift codes, and
// the secondary field union
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package exec_isa_pkg;

  localparam int ALU_OPC_W = 4;

  // primary opcode, unlisted codes are no-ops
  typedef enum logic [ALU_OPC_W-1:0] {
    OPC_ADD     = 4'h0,
    OPC_ADDC    = 4'h1,
    OPC_SUB     = 4'h2,
    OPC_AND     = 4'h3,
    OPC_OR      = 4'h4,
    OPC_XOR     = 4'h5,
    OPC_MUL     = 4'h6,
    OPC_SHRT    = 4'h8,
    OPC_SETFLAG = 4'h9,
    OPC_MOVHI   = 4'hA,
    OPC_CMOV    = 4'hE,
    OPC_FFL1    = 4'hF
  } alu_opc_e;

  // set-flag compare codes
  typedef enum logic [3:0] {
    CMP_EQ  = 4'd0,
    CMP_NE  = 4'd1,
    CMP_GTU = 4'd2,
    CMP_GTS = 4'd3,
    CMP_GEU = 4'd4,
    CMP_GES = 4'd5,
    CMP_LTU = 4'd6,
    CMP_LTS = 4'd7,
    CMP_LEU = 4'd8,
    CMP_LES = 4'd9
  } cmp_opc_e;

  typedef enum logic [1:0] {SHR_SLL, SHR_SRL, SHR_SRA, SHR_ROR} shr_opc_e;

  // secondary field, read as compare code or as shift/ffl1 control
  typedef union packed {
    cmp_opc_e cmp;
    struct packed {
      logic     rsvd;
      logic     fl1;   // find last one when set
      shr_opc_e kind;
    } shr;
  } alu_sec_u;

endpackage

// File: exec_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-back assertions and
// their bind onto wb_result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module exec_properties (
  input logic clk,
  input logic rst,
  input logic flush_i,
  input logic alu_rdy_q,
  input logic mul_rdy_q,
  input logic wb_flag_set_o,
  input logic wb_flag_clear_o,
  input logic wb_carry_set_o,
  input logic wb_carry_clear_o,
  input logic wb_ovf_set_o,
  input logic wb_ovf_clear_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int n_fail;

  // each pair is one-hot or idle
  assert property (@(posedge clk) disable iff (rst)
    !(wb_flag_set_o && wb_flag_clear_o))
    else begin
      $error("flag set and clear both high");
      n_fail++;
    end
  assert property (@(posedge clk) disable iff (rst)
    !(wb_carry_set_o && wb_carry_clear_o))
    else begin
      $error("carry set and clear both high");
      n_fail++;
    end
  assert property (@(posedge clk) disable iff (rst)
    !(wb_ovf_set_o && wb_ovf_clear_o))
    else begin
      $error("ovf set and clear both high");
      n_fail++;
    end

  assert property (@(posedge clk) disable iff (rst)
    !(alu_rdy_q && mul_rdy_q))
    else begin
      $error("alu and mul ready together");
      n_fail++;
    end

  assert property (@(posedge clk) (rst || flush_i) |=>
    !(alu_rdy_q || mul_rdy_q || wb_flag_set_o || wb_flag_clear_o ||
      wb_carry_set_o || wb_carry_clear_o || wb_ovf_set_o || wb_ovf_clear_o))
    else begin
      $error("ready or flag output high after reset or flush");
      n_fail++;
    end

endmodule

bind wb_result exec_properties i_props (
  .clk              (clk),
  .rst              (rst),
  .flush_i          (flush_i),
  .alu_rdy_q        (alu_rdy_q),
  .mul_rdy_q        (mul_rdy_q),
  .wb_flag_set_o    (wb_flag_set_o),
  .wb_flag_clear_o  (wb_flag_clear_o),
  .wb_carry_set_o   (wb_carry_set_o),
  .wb_carry_clear_o (wb_carry_clear_o),
  .wb_ovf_set_o     (wb_ovf_set_o),
  .wb_ovf_clear_o   (wb_ovf_clear_o)
);

// File: exec_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage testbench, clock,
// stimulus, watchdog, verdict
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module exec_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import exec_cfg_pkg::*;
  import exec_isa_pkg::*;

  localparam int N_ALU     = 200;
  localparam int N_CMP     = 120;
  localparam int N_MUL     = 120;
  localparam int N_BP      = 120;
  localparam int N_FL      = 10;
  localparam int MAX_STALL = 6;
  localparam int RST_CYC   = 10;
  // worst case two cycles per insn plus stalls and drains
  localparam int RUN_CYC = 2 * (N_ALU + N_CMP + N_MUL + N_BP) + N_BP * MAX_STALL +
                           N_FL * 16 + 5 * 12 + 20;

  logic     clk;
  logic     rst;
  logic     flush_i;
  logic     padv_wb_i;
  logic     insn_valid_i;
  alu_opc_e opc_i;
  alu_sec_u sec_i;
  data_t    rfa_i;
  data_t    rfb_i;
  data_t    imm_i;
  logic     imm_sel_i;
  logic     flag_i;
  logic     carry_i;
  logic     exec_valid_o;
  data_t    wb_result_o;
  logic     wb_rdy_o;
  logic     wb_flag_set_o;
  logic     wb_flag_clear_o;
  logic     wb_carry_set_o;
  logic     wb_carry_clear_o;
  logic     wb_ovf_set_o;
  logic     wb_ovf_clear_o;
  int       seed;
  int       test_id;
  logic     test_end;
  logic     all_done;
  int       err_total;

  exec_top i_exec_top (.*);

  exec_checker i_checker (
    .clk (clk), .rst (rst), .flush_i (flush_i), .padv_wb_i (padv_wb_i),
    .insn_valid_i (insn_valid_i), .opc_i (opc_i), .sec_i (sec_i),
    .rfa_i (rfa_i), .rfb_i (rfb_i), .imm_i (imm_i), .imm_sel_i (imm_sel_i),
    .flag_i (flag_i), .carry_i (carry_i), .exec_valid_i (exec_valid_o),
    .wb_result_i (wb_result_o), .wb_rdy_i (wb_rdy_o),
    .wb_flags_i ({wb_flag_set_o, wb_flag_clear_o, wb_carry_set_o,
                  wb_carry_clear_o, wb_ovf_set_o, wb_ovf_clear_o}),
    .test_id_i (test_id), .test_end_i (test_end), .all_done_i (all_done),
    .err_total_o (err_total)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #((RST_CYC + RUN_CYC) * 20);
    $display("watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

  task automatic issue(input logic [3:0] opc, input logic [3:0] sec,
                       input data_t a, input data_t b, input logic isel);
    @(posedge clk);
    insn_valid_i <= 1'b1;
    opc_i        <= alu_opc_e'(opc);
    sec_i        <= alu_sec_u'(sec);
    rfa_i        <= a;
    rfb_i        <= b;
    imm_i        <= $random(seed);
    imm_sel_i    <= isel;
    flag_i       <= $random(seed);
    carry_i      <= $random(seed);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      insn_valid_i <= 1'b0;
    end
  endtask

  task automatic stall(input int n);
    @(posedge clk);
    insn_valid_i <= 1'b0;
    padv_wb_i    <= 1'b0;
    repeat (n - 1) @(posedge clk);
    @(posedge clk);
    padv_wb_i <= 1'b1;
  endtask

  task automatic finish_test(input int id);
    idle(8);
    @(posedge clk);
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
    test_id  <= id + 1;
  endtask

  // random word or an edge value for compares
  function automatic data_t pick_operand();
    int k;
    k = ($random(seed) & 32'h7fff_ffff) % 6;
    case (k)
      0: return 32'h8000_0000;
      1: return 32'h7fff_ffff;
      2: return 32'hffff_ffff;
      3: return 32'h0000_0000;
      default: return $random(seed);
    endcase
  endfunction

  initial begin
    logic [3:0] opc;
    data_t      a;
    seed = 74249;
    rst = 1'b1;
    flush_i = 1'b0;
    padv_wb_i = 1'b1;
    insn_valid_i = 1'b0;
    opc_i = OPC_ADD;
    sec_i = '0;
    rfa_i = '0;
    rfb_i = '0;
    imm_i = '0;
    imm_sel_i = 1'b0;
    flag_i = 1'b0;
    carry_i = 1'b0;
    test_id = 0;
    test_end = 1'b0;
    all_done = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    rst <= 1'b0;
    idle(2);

    repeat (N_ALU) begin
      opc = $random(seed);
      if (opc == OPC_MUL)
        opc = OPC_ADDC;
      issue(opc, $random(seed), $random(seed), $random(seed), $random(seed));
      if (($random(seed) & 3) == 0)
        idle(1);
    end
    finish_test(0);

    repeat (N_CMP) begin
      a = pick_operand();
      issue(OPC_SETFLAG, $random(seed), a, ($random(seed) & 1) ? a : pick_operand(), 1'b0);
    end
    finish_test(1);

    repeat (N_MUL) issue(OPC_MUL, 4'h0, $random(seed), $random(seed), $random(seed));
    finish_test(2);

    repeat (N_BP) begin
      issue(OPC_MUL, 4'h0, $random(seed), $random(seed), $random(seed));
      if (($random(seed) & 3) == 0)
        stall(1 + (($random(seed) & 32'hff) % MAX_STALL));
    end
    finish_test(3);

    repeat (N_FL) begin
      repeat (1 + ($random(seed) & 1)) issue(OPC_MUL, 4'h0, $random(seed), $random(seed), 1'b0);
      @(posedge clk);
      insn_valid_i <= 1'b0;
      flush_i      <= 1'b1;
      @(posedge clk);
      flush_i <= 1'b0;
      idle(3);
      issue(OPC_ADD, 4'h0, $random(seed), $random(seed), 1'b0);  // next insn after flush
      idle(1);
      issue(OPC_MUL, 4'h0, $random(seed), $random(seed), 1'b0);
      idle(5);
    end
    finish_test(4);

    @(posedge clk);
    all_done <= 1'b1;
    @(posedge clk);
    all_done <= 1'b0;
    @(posedge clk);
    if (err_total == 0 && i_exec_top.i_wb.i_props.n_fail == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: exec_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer execute stage top,
// decode, alu, mul, write-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module exec_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   flush_i,
  input  logic                   padv_wb_i,
  input  logic                   insn_valid_i,
  input  exec_isa_pkg::alu_opc_e opc_i,
  input  exec_isa_pkg::alu_sec_u sec_i,
  input  exec_cfg_pkg::data_t    rfa_i,
  input  exec_cfg_pkg::data_t    rfb_i,
  input  exec_cfg_pkg::data_t    imm_i,
  input  logic                   imm_sel_i,
  input  logic                   flag_i,    // for cmov
  input  logic                   carry_i,   // for addc
  output logic                   exec_valid_o,
  output exec_cfg_pkg::data_t    wb_result_o,
  output logic                   wb_rdy_o,
  output logic                   wb_flag_set_o,
  output logic                   wb_flag_clear_o,
  output logic                   wb_carry_set_o,
  output logic                   wb_carry_clear_o,
  output logic                   wb_ovf_set_o,
  output logic                   wb_ovf_clear_o
);

  unit_sel_if sel_if ();
  unit_res_if res_if ();

  exec_decode i_decode (
    .insn_valid_i (insn_valid_i),
    .opc_i        (opc_i),
    .sec_i        (sec_i),
    .rfa_i        (rfa_i),
    .rfb_i        (rfb_i),
    .imm_i        (imm_i),
    .imm_sel_i    (imm_sel_i),
    .sel          (sel_if)
  );

  alu_1clk i_alu (
    .sel     (sel_if),
    .flag_i  (flag_i),
    .carry_i (carry_i),
    .res     (res_if)
  );

  mul_pipe i_mul (
    .clk       (clk),
    .rst       (rst),
    .flush_i   (flush_i),
    .padv_wb_i (padv_wb_i),
    .sel       (sel_if),
    .res       (res_if)
  );

  wb_result i_wb (
    .clk              (clk),
    .rst              (rst),
    .flush_i          (flush_i),
    .padv_wb_i        (padv_wb_i),
    .res              (res_if),
    .wb_result_o      (wb_result_o),
    .wb_rdy_o         (wb_rdy_o),
    .wb_flag_set_o    (wb_flag_set_o),
    .wb_flag_clear_o  (wb_flag_clear_o),
    .wb_carry_set_o   (wb_carry_set_o),
    .wb_carry_clear_o (wb_carry_clear_o),
    .wb_ovf_set_o     (wb_ovf_set_o),
    .wb_ovf_clear_o   (wb_ovf_clear_o)
  );

  // one-cycle op in flight or product waiting for write-back
  assign exec_valid_o = res_if.alu_valid | res_if.mul_valid;

endmodule

// File: mul_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipelined 32x32 low-word
// multiplier with stall control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mul_pipe (
  input  logic        clk,
  input  logic        rst,
  input  logic        flush_i,
  input  logic        padv_wb_i,
  unit_sel_if.mul     sel,
  unit_res_if.mul_src res
);
  import exec_cfg_pkg::*;

  logic  mul_adv;   // stages may move
  logic  s1_rdy;
  logic  s2_rdy;
  half_t s1_al;
  half_t s1_ah;
  half_t s1_bl;
  half_t s1_bh;
  data_t s2_albl;
  data_t s2_ahbl;
  data_t s2_bhal;

  // a held product only freezes the pipe when write-back stalls
  assign mul_adv = ~s2_rdy | padv_wb_i;

  // stage one, operand halves
  always_ff @(posedge clk) begin
    if (sel.mul_go & mul_adv) begin
      s1_al <= sel.op_a[HALF_W-1:0];
      s1_ah <= sel.op_a[DATA_W-1:HALF_W];
      s1_bl <= sel.op_b[HALF_W-1:0];
      s1_bh <= sel.op_b[DATA_W-1:HALF_W];
    end
  end

  // stage two, partial products (ah*bh drops out of the low word)
  always_ff @(posedge clk) begin
    if (s1_rdy & mul_adv) begin
      s2_albl <= s1_al * s1_bl;
      s2_ahbl <= s1_ah * s1_bl;
      s2_bhal <= s1_bh * s1_al;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      s1_rdy <= 1'b0;
      s2_rdy <= 1'b0;
    end else if (mul_adv) begin
      s1_rdy <= sel.mul_go;
      s2_rdy <= s1_rdy;
    end
  end

  assign res.mul_valid  = s2_rdy;
  assign res.mul_result = {s2_bhal[HALF_W-1:0], {HALF_W{1'b0}}} +
                          {s2_ahbl[HALF_W-1:0], {HALF_W{1'b0}}} +
                          s2_albl;

endmodule

// File: wb_result.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-back registers, result
// mux and flag pair outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module wb_result (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush_i,
  input  logic                padv_wb_i,
  unit_res_if.wb              res,
  output exec_cfg_pkg::data_t wb_result_o,
  output logic                wb_rdy_o,
  output logic                wb_flag_set_o,
  output logic                wb_flag_clear_o,
  output logic                wb_carry_set_o,
  output logic                wb_carry_clear_o,
  output logic                wb_ovf_set_o,
  output logic                wb_ovf_clear_o
);
  import exec_cfg_pkg::*;

  data_t alu_res_q;
  data_t mul_res_q;
  logic  alu_rdy_q;
  logic  mul_rdy_q;

  always_ff @(posedge clk) begin
    if (padv_wb_i && res.alu_valid)
      alu_res_q <= res.alu_result;
    if (padv_wb_i && res.mul_valid)
      mul_res_q <= res.mul_result;
  end

  // ready bits and flag pairs, all hold while wb stalls
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      alu_rdy_q        <= 1'b0;
      mul_rdy_q        <= 1'b0;
      wb_flag_set_o    <= 1'b0;
      wb_flag_clear_o  <= 1'b0;
      wb_carry_set_o   <= 1'b0;
      wb_carry_clear_o <= 1'b0;
      wb_ovf_set_o     <= 1'b0;
      wb_ovf_clear_o   <= 1'b0;
    end else if (padv_wb_i) begin
      alu_rdy_q        <= res.alu_valid;
      mul_rdy_q        <= res.mul_valid;
      wb_flag_set_o    <= res.setflag_op & res.flag_set;
      wb_flag_clear_o  <= res.setflag_op & ~res.flag_set;
      wb_carry_set_o   <= res.add_op & res.carry_out;
      wb_carry_clear_o <= res.add_op & ~res.carry_out;
      wb_ovf_set_o     <= res.add_op & res.s_ovf;
      wb_ovf_clear_o   <= res.add_op & ~res.s_ovf;
    end
  end

  // seen once, in the first cycle wb advances
  assign wb_rdy_o    = (alu_rdy_q | mul_rdy_q) & padv_wb_i;
  assign wb_result_o = alu_rdy_q ? alu_res_q :
                       mul_rdy_q ? mul_res_q : '0;

endmodule
